/* include/ew_macros.svh */
// widths shared by RTL and testbench; the int datapath assumes EW_DATA_W of 32
// and EW_IN_W no wider than EW_DATA_W
`ifndef EW_MACROS_SVH
`define EW_MACROS_SVH

// ===========================================================================
// stream widths
// ===========================================================================
`define EW_IN_W 16        // operand stream width
`define EW_DATA_W 32      // main data width

// ===========================================================================
// register field widths
// ===========================================================================
`define EW_CVT_SHIFT_W 6  // converter truncate field
`define EW_MUL_SHIFT_W 10 // multiplier truncate field
`define EW_SCALE_W 16     // converter scale field

`endif

/* hw/ew_data_pkg.sv */
// payload types for the integer y datapath
`default_nettype none

`include "ew_macros.svh"

package ew_data_pkg;

  // ===========================================================================
  // stream payloads
  // ===========================================================================
  typedef logic signed [`EW_IN_W-1:0] ew_operand_t;   // raw operand beat
  typedef logic signed [`EW_DATA_W-1:0] ew_data_t;    // data word, converted operand

  // ===========================================================================
  // alu algorithm encoding
  // ===========================================================================
  typedef enum logic [1:0] {
    EW_ALU_MAX  = 2'd0,   // reset value
    EW_ALU_MIN  = 2'd1,
    EW_ALU_ADD  = 2'd2,   // saturating
    EW_ALU_PASS = 2'd3
  } ew_alu_algo_e;

endpackage

`default_nettype wire

/* hw/ew_cfg_pkg.sv */
// register set layouts; all-zero means bypass off, algo max, register operands
`default_nettype none

`include "ew_macros.svh"

package ew_cfg_pkg;
  import ew_data_pkg::*;

  typedef struct packed {
    logic bypass;
    ew_data_t offset;                       // subtracted before scaling
    logic signed [`EW_SCALE_W-1:0] scale;
    logic [`EW_CVT_SHIFT_W-1:0] truncate;   // arithmetic right shift
  } ew_cvt_cfg_t;

  typedef struct packed {
    logic bypass;
    ew_alu_algo_e algo;
    logic src;                              // 1 = operand from stream
    ew_data_t operand;
  } ew_alu_cfg_t;

  typedef struct packed {
    logic bypass;
    logic prelu;                            // scale negative values only
    logic src;
    ew_data_t operand;
    logic [`EW_MUL_SHIFT_W-1:0] truncate;
  } ew_mul_cfg_t;

  typedef struct packed {
    ew_cvt_cfg_t alu_cvt;
    ew_cvt_cfg_t mul_cvt;
    ew_alu_cfg_t alu;
    ew_mul_cfg_t mul;
  } ew_cfg_t;

endpackage

`default_nettype wire

/* hw/ew_operand_cvt.sv */
// single-slot converter; cfg must stay stable while an item is held
// result saturates to the signed EW_DATA_W range
`timescale 1ns/1ps
`default_nettype none

`include "ew_macros.svh"

module ew_operand_cvt
  import ew_data_pkg::*, ew_cfg_pkg::*;
(
  input  wire         autosa_core_clk,
  input  wire         autosa_core_rstn,
  input  ew_cvt_cfg_t cfg,
  input  ew_operand_t in_pd,
  input  wire         in_pvld,
  output logic        in_prdy,
  output ew_data_t    out_pd,
  output logic        out_pvld,
  input  wire         out_prdy
);

  localparam int DIFF_W = `EW_DATA_W + 1;          // input minus 32-bit offset
  localparam int PROD_W = DIFF_W + `EW_SCALE_W;    // 49-bit intermediate
  localparam longint SAT_MAX = (longint'(1) <<< (`EW_DATA_W - 1)) - 1;
  localparam longint SAT_MIN = -SAT_MAX - 1;

  logic signed [DIFF_W-1:0] diff;
  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] shifted;
  ew_data_t                 cvt_val;

  // ===========================================================================
  // offset, scale, shift, saturate
  // ===========================================================================
  always_comb begin
    diff    = DIFF_W'(in_pd) - DIFF_W'(cfg.offset);
    prod    = diff * cfg.scale;
    shifted = prod >>> cfg.truncate;
    if (cfg.bypass) begin
      cvt_val = in_pd;                                // sign-extended
    end else if (shifted > SAT_MAX) begin
      cvt_val = ew_data_t'(SAT_MAX);
    end else if (shifted < SAT_MIN) begin
      cvt_val = ew_data_t'(SAT_MIN);
    end else begin
      cvt_val = shifted[`EW_DATA_W-1:0];
    end
  end

  // ===========================================================================
  // output slot
  // ===========================================================================
  assign in_prdy = !out_pvld || out_prdy;            // empty or draining

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      out_pvld <= 1'b0;
    end else if (in_prdy) begin
      out_pvld <= in_pvld;
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (in_pvld && in_prdy) begin
      out_pd <= cvt_val;
    end
  end

endmodule

`default_nettype wire

/* hw/ew_alu_mul_core.sv */
// two-stage alu then multiply; cfg may change only while the pipeline is empty
// stream operands are popped only when their stage uses them
`timescale 1ns/1ps
`default_nettype none

`include "ew_macros.svh"

module ew_alu_mul_core
  import ew_data_pkg::*, ew_cfg_pkg::*;
(
  input  wire         autosa_core_clk,
  input  wire         autosa_core_rstn,
  input  ew_alu_cfg_t alu_cfg,
  input  ew_mul_cfg_t mul_cfg,
  input  ew_data_t    data_pd,
  input  wire         data_pvld,
  output logic        data_prdy,
  input  ew_data_t    alu_op_pd,
  input  wire         alu_op_pvld,
  output logic        alu_op_prdy,
  input  ew_data_t    mul_op_pd,
  input  wire         mul_op_pvld,
  output logic        mul_op_prdy,
  output ew_data_t    out_pd,
  output logic        out_pvld,
  input  wire         out_prdy
);

  localparam longint SAT_MAX = (longint'(1) <<< (`EW_DATA_W - 1)) - 1;
  localparam longint SAT_MIN = -SAT_MAX - 1;

  logic     alu_use, mul_use;
  logic     alu_ok, mul_ok;
  logic     join_go;
  logic     s1_vld, s1_rdy, s2_vld, s2_rdy;
  ew_data_t alu_op, mul_op, alu_res, mul_res;
  ew_data_t s1_data, s1_mul_op, s2_data;

  function automatic ew_data_t sat_data(input logic signed [63:0] v);
    if (v > SAT_MAX) return ew_data_t'(SAT_MAX);
    if (v < SAT_MIN) return ew_data_t'(SAT_MIN);
    return v[`EW_DATA_W-1:0];
  endfunction

  // ===========================================================================
  // join
  // ===========================================================================
  assign alu_use = !alu_cfg.bypass && alu_cfg.src;
  assign mul_use = !mul_cfg.bypass && mul_cfg.src;
  assign alu_ok  = !alu_use || alu_op_pvld;          // operand present or not needed
  assign mul_ok  = !mul_use || mul_op_pvld;

  assign s2_rdy  = !s2_vld || out_prdy;
  assign s1_rdy  = !s1_vld || s2_rdy;

  assign data_prdy   = s1_rdy && alu_ok && mul_ok;
  assign alu_op_prdy = alu_use && s1_rdy && data_pvld && mul_ok;
  assign mul_op_prdy = mul_use && s1_rdy && data_pvld && alu_ok;
  assign join_go     = data_pvld && data_prdy;

  // ===========================================================================
  // stage one, alu
  // ===========================================================================
  always_comb begin
    alu_op = alu_cfg.src ? alu_op_pd : alu_cfg.operand;
    mul_op = mul_cfg.src ? mul_op_pd : mul_cfg.operand;  // carried to stage two
    if (alu_cfg.bypass) begin
      alu_res = data_pd;
    end else begin
      case (alu_cfg.algo)
        EW_ALU_MAX: alu_res = (data_pd > alu_op) ? data_pd : alu_op;
        EW_ALU_MIN: alu_res = (data_pd < alu_op) ? data_pd : alu_op;
        EW_ALU_ADD: alu_res = sat_data(64'(data_pd) + 64'(alu_op));
        default:    alu_res = data_pd;                  // pass
      endcase
    end
  end

  // ===========================================================================
  // stage two, multiply and shift
  // ===========================================================================
  always_comb begin
    if (mul_cfg.bypass) begin
      mul_res = s1_data;
    end else if (mul_cfg.prelu && !s1_data[`EW_DATA_W-1]) begin
      mul_res = s1_data;                                // prelu keeps positives
    end else begin
      mul_res = sat_data((64'(s1_data) * 64'(s1_mul_op)) >>> mul_cfg.truncate);
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else begin
      if (s1_rdy) s1_vld <= join_go;
      if (s2_rdy) s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (join_go) begin
      s1_data   <= alu_res;
      s1_mul_op <= mul_op;
    end
    if (s1_vld && s2_rdy) begin
      s2_data <= mul_res;
    end
  end

  assign out_pvld = s2_vld;
  assign out_pd   = s2_data;

endmodule

`default_nettype wire

/* hw/ew_y_core.sv */
// integer y stage top; load a new reg_cfg only while the pipeline is empty
`timescale 1ns/1ps
`default_nettype none

module ew_y_core
  import ew_data_pkg::*, ew_cfg_pkg::*;
(
  input  wire         autosa_core_clk,
  input  wire         autosa_core_rstn,
  input  wire         op_en_load,
  input  ew_cfg_t     reg_cfg,
  input  ew_operand_t alu_in_pd,
  input  wire         alu_in_pvld,
  output logic        alu_in_prdy,
  input  ew_operand_t mul_in_pd,
  input  wire         mul_in_pvld,
  output logic        mul_in_prdy,
  input  ew_data_t    data_in_pd,
  input  wire         data_in_pvld,
  output logic        data_in_prdy,
  output ew_data_t    data_out_pd,
  output logic        data_out_pvld,
  input  wire         data_out_prdy
);

  ew_cfg_t  cfg;
  ew_data_t alu_cvt_pd, mul_cvt_pd;
  logic     alu_cvt_pvld, alu_cvt_prdy;
  logic     mul_cvt_pvld, mul_cvt_prdy;

  // ===========================================================================
  // configuration capture
  // ===========================================================================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cfg <= '0;
    end else if (op_en_load) begin
      cfg <= reg_cfg;              // used from the next cycle
    end
  end

  // ===========================================================================
  // operand converters and core
  // ===========================================================================
  ew_operand_cvt u_alu_cvt (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cfg              (cfg.alu_cvt),
    .in_pd            (alu_in_pd),
    .in_pvld          (alu_in_pvld),
    .in_prdy          (alu_in_prdy),
    .out_pd           (alu_cvt_pd),
    .out_pvld         (alu_cvt_pvld),
    .out_prdy         (alu_cvt_prdy)
  );

  ew_operand_cvt u_mul_cvt (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cfg              (cfg.mul_cvt),
    .in_pd            (mul_in_pd),
    .in_pvld          (mul_in_pvld),
    .in_prdy          (mul_in_prdy),
    .out_pd           (mul_cvt_pd),
    .out_pvld         (mul_cvt_pvld),
    .out_prdy         (mul_cvt_prdy)
  );

  ew_alu_mul_core u_core (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .alu_cfg          (cfg.alu),
    .mul_cfg          (cfg.mul),
    .data_pd          (data_in_pd),
    .data_pvld        (data_in_pvld),
    .data_prdy        (data_in_prdy),
    .alu_op_pd        (alu_cvt_pd),
    .alu_op_pvld      (alu_cvt_pvld),
    .alu_op_prdy      (alu_cvt_prdy),
    .mul_op_pd        (mul_cvt_pd),
    .mul_op_pvld      (mul_cvt_pvld),
    .mul_op_prdy      (mul_cvt_prdy),
    .out_pd           (data_out_pd),
    .out_pvld         (data_out_pvld),
    .out_prdy         (data_out_prdy)
  );

endmodule

`default_nettype wire

/* tb/ew_y_core_assertions.sv */
// handshake checks on the y stage; the clock must run while reset is held
`timescale 1ns/1ps
`default_nettype none

module ew_y_core_assertions
  import ew_data_pkg::*;
(
  input wire      autosa_core_clk,
  input wire      autosa_core_rstn,
  input ew_data_t data_out_pd,
  input wire      data_out_pvld,
  input wire      data_out_prdy,
  input wire      alu_cvt_pvld,
  input wire      mul_cvt_pvld
);

  int fail_count = 0;   // assertion failures so far

  // ===========================================================================
  // reset and output stream rules
  // ===========================================================================
  a_reset_idle: assert property (@(posedge autosa_core_clk)
      !autosa_core_rstn |-> !(data_out_pvld || alu_cvt_pvld || mul_cvt_pvld))
    else begin
      fail_count++;
      $error("pvld high while reset is asserted");
    end

  a_pvld_held: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
      data_out_pvld && !data_out_prdy |=> data_out_pvld)
    else begin
      fail_count++;
      $error("data_out_pvld dropped before the transfer");
    end

  a_pd_stable: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
      data_out_pvld && !data_out_prdy |=> $stable(data_out_pd))
    else begin
      fail_count++;
      $error("data_out_pd changed while stalled");
    end

endmodule

`default_nettype wire

/* tb/ew_y_core_tb.sv */
// run from the project root; vectors come from tb/ew_y_core_input.txt
// one vector is in flight at a time because every line carries its own cfg
`timescale 1ns/1ps
`default_nettype none

`include "ew_macros.svh"

module ew_y_core_tb
  import ew_data_pkg::*, ew_cfg_pkg::*;
();

  localparam int MAX_VEC = 64;

  logic        autosa_core_clk;
  logic        autosa_core_rstn;
  logic        op_en_load;
  ew_cfg_t     reg_cfg;
  ew_operand_t alu_in_pd, mul_in_pd;
  logic        alu_in_pvld, alu_in_prdy, mul_in_pvld, mul_in_prdy;
  ew_data_t    data_in_pd, data_out_pd;
  logic        data_in_pvld, data_in_prdy, data_out_pvld, data_out_prdy;

  ew_cfg_t     cfg_v [MAX_VEC];
  logic [31:0] tag_v [MAX_VEC];              // 0 keeps the reset cfg
  ew_data_t    data_v [MAX_VEC];
  ew_data_t    exp_v [MAX_VEC];
  ew_operand_t ain_v [MAX_VEC];
  ew_operand_t min_v [MAX_VEC];
  ew_data_t    exp_q [$];                    // results still owed by the DUT
  int          nvec = 0;
  int          n_out = 0;
  int          n_err = 0;
  logic        loaded = 1'b0;
  logic [31:0] rng = 32'd6;

  ew_y_core i_ew_y_core (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_en_load       (op_en_load),
    .reg_cfg          (reg_cfg),
    .alu_in_pd        (alu_in_pd),
    .alu_in_pvld      (alu_in_pvld),
    .alu_in_prdy      (alu_in_prdy),
    .mul_in_pd        (mul_in_pd),
    .mul_in_pvld      (mul_in_pvld),
    .mul_in_prdy      (mul_in_prdy),
    .data_in_pd       (data_in_pd),
    .data_in_pvld     (data_in_pvld),
    .data_in_prdy     (data_in_prdy),
    .data_out_pd      (data_out_pd),
    .data_out_pvld    (data_out_pvld),
    .data_out_prdy    (data_out_prdy)
  );

  bind ew_y_core ew_y_core_assertions u_ew_y_core_assertions (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .data_out_pd      (data_out_pd),
    .data_out_pvld    (data_out_pvld),
    .data_out_prdy    (data_out_prdy),
    .alu_cvt_pvld     (alu_cvt_pvld),
    .mul_cvt_pvld     (mul_cvt_pvld)
  );

  initial begin
    autosa_core_clk = 1'b0;
    forever #10 autosa_core_clk = ~autosa_core_clk;   // 20 ns period
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);                           // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    if (got !== want) begin
      n_err++;
      $display("Error at %0t ns: %s got %h, expected %h", $time, what, got, want);
    end
  endtask

  // ===========================================================================
  // stimulus drivers, each beat held until taken
  // ===========================================================================
  task automatic load_cfg(input ew_cfg_t c);
    @(posedge autosa_core_clk);
    #1;
    reg_cfg    = c;
    op_en_load = 1'b1;
    @(posedge autosa_core_clk);
    #1;
    op_en_load = 1'b0;
  endtask

  task automatic send_data(input ew_data_t v);
    @(posedge autosa_core_clk);
    #1;
    data_in_pd   = v;
    data_in_pvld = 1'b1;
    do @(negedge autosa_core_clk); while (!data_in_prdy);
    @(posedge autosa_core_clk);
    #1;
    data_in_pvld = 1'b0;
  endtask

  task automatic send_alu(input ew_operand_t v);
    @(posedge autosa_core_clk);
    #1;
    alu_in_pd   = v;
    alu_in_pvld = 1'b1;
    do @(negedge autosa_core_clk); while (!alu_in_prdy);
    @(posedge autosa_core_clk);
    #1;
    alu_in_pvld = 1'b0;
  endtask

  task automatic send_mul(input ew_operand_t v);
    @(posedge autosa_core_clk);
    #1;
    mul_in_pd   = v;
    mul_in_pvld = 1'b1;
    do @(negedge autosa_core_clk); while (!mul_in_prdy);
    @(posedge autosa_core_clk);
    #1;
    mul_in_pvld = 1'b0;
  endtask

  // ===========================================================================
  // output side, random back-pressure and in-order compare
  // ===========================================================================
  initial begin : consumer
    ew_data_t want;
    data_out_prdy = 1'b0;
    wait (autosa_core_rstn);
    forever begin
      @(posedge autosa_core_clk);
      #1 data_out_prdy = (next_rand() % 10) < 7;       // ready about 70 %
      @(negedge autosa_core_clk);
      if (data_out_pvld && data_out_prdy) begin
        n_out++;
        if (exp_q.size() == 0) begin
          n_err++;
          $display("unexpected extra output %h at %0t ns", data_out_pd, $time);
        end else begin
          want = exp_q.pop_front();
          check_value(data_out_pd, want, "data_out_pd");
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (nvec * 40 + 200) @(posedge autosa_core_clk);
    $display("timeout: results stopped arriving within %0d cycles", nvec * 40 + 200);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [22];
    logic        alu_use, mul_use;

    autosa_core_rstn = 1'b0;
    op_en_load   = 1'b0;
    reg_cfg      = '0;
    alu_in_pd    = '0;
    alu_in_pvld  = 1'b0;
    mul_in_pd    = '0;
    mul_in_pvld  = 1'b0;
    data_in_pd   = '0;
    data_in_pvld = 1'b0;

    fd = $fopen("tb/ew_y_core_input.txt", "r");
    if (fd == 0) begin
      n_err++;
      $display("could not open tb/ew_y_core_input.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                      f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                      f[21]);
        if (cnt != 22 || nvec == MAX_VEC) begin
          n_err++;
          $display("skipped a malformed or surplus vector line: %s", line);
        end else begin
          tag_v[nvec]         = f[0];
          cfg_v[nvec].alu_cvt = {f[1][0], f[2], f[3][`EW_SCALE_W-1:0],
                                 f[4][`EW_CVT_SHIFT_W-1:0]};
          cfg_v[nvec].mul_cvt = {f[5][0], f[6], f[7][`EW_SCALE_W-1:0],
                                 f[8][`EW_CVT_SHIFT_W-1:0]};
          cfg_v[nvec].alu     = {f[9][0], f[10][1:0], f[11][0], f[12]};
          cfg_v[nvec].mul     = {f[13][0], f[14][0], f[15][0], f[16],
                                 f[17][`EW_MUL_SHIFT_W-1:0]};
          data_v[nvec]        = f[18];
          ain_v[nvec]         = f[19][`EW_IN_W-1:0];
          min_v[nvec]         = f[20][`EW_IN_W-1:0];
          exp_v[nvec]         = f[21];
          nvec++;
        end
      end
      $fclose(fd);
    end
    if (nvec == 0) begin
      n_err++;
      $display("no test vectors were read");
    end
    loaded = 1'b1;

    repeat (2) @(posedge autosa_core_clk);
    #1 autosa_core_rstn = 1'b1;
    repeat (3) begin
      @(negedge autosa_core_clk);
      check_value(data_out_pvld, 1'b0, "data_out_pvld before first beat");
    end

    for (int i = 0; i < nvec; i++) begin
      if (tag_v[i] != 0) load_cfg(cfg_v[i]);
      alu_use = !cfg_v[i].alu.bypass && cfg_v[i].alu.src;   // join rule
      mul_use = !cfg_v[i].mul.bypass && cfg_v[i].mul.src;
      exp_q.push_back(exp_v[i]);
      fork
        send_data(data_v[i]);
        if (alu_use) send_alu(ain_v[i]);
        if (mul_use) send_mul(min_v[i]);
      join
      wait (n_out == i + 1);
      @(negedge autosa_core_clk);
      check_value(alu_in_prdy, 1'b1, "alu_in_prdy with pipeline drained");
      check_value(mul_in_prdy, 1'b1, "mul_in_prdy with pipeline drained");
    end

    repeat (10) @(posedge autosa_core_clk);             // catch stray outputs
    check_value(n_out, nvec, "output count");
    n_err += i_ew_y_core.u_ew_y_core_assertions.fail_count;
    $display("summary: %0d vectors, %0d outputs, %0d errors", nvec, n_out, n_err);
    if (n_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ew_y_core_input.txt */
# tag | alu_cvt: byp off scale trunc | mul_cvt: byp off scale trunc | alu: byp algo src op
# mul: byp prelu src op trunc | data alu_in mul_in expected   (all hex, tag 0 = reset cfg)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 a 1 0 0 0 0 3 0 0 a
1 0 0 0 0 0 0 0 0 0 0 0 fffffffb 1 0 0 0 0 fffffff7 0 0 fffffffb
1 0 0 0 0 0 0 0 0 0 1 0 64 1 0 0 0 0 7b 0 0 64
1 0 0 0 0 0 0 0 0 0 1 0 ffffffff 1 0 0 0 0 2 0 0 ffffffff
1 0 0 0 0 0 0 0 0 0 2 0 10 1 0 0 0 0 20 0 0 30
1 0 0 0 0 0 0 0 0 0 2 0 7fffffff 1 0 0 0 0 1 0 0 7fffffff
1 0 0 0 0 0 0 0 0 0 2 0 80000000 1 0 0 0 0 ffffffff 0 0 80000000
1 0 0 0 0 0 0 0 0 0 3 0 5 1 0 0 0 0 1234 0 0 1234
1 0 0 0 0 0 0 0 0 1 2 0 5 1 0 0 0 0 abc 0 0 abc
2 0 a 3 1 0 0 0 0 0 2 1 0 1 0 0 0 0 0 32 0 3c
2 0 14 2 0 0 0 0 0 0 2 1 0 1 0 0 0 0 0 fff6 0 ffffffc4
2 0 0 1 2 0 0 0 0 0 2 1 0 1 0 0 0 0 0 fff9 0 fffffffe
2 0 80000000 7fff 0 0 0 0 0 0 2 1 0 1 0 0 0 0 0 7fff 0 7fffffff
2 0 7fffffff 7fff 0 0 0 0 0 0 2 1 0 1 0 0 0 0 0 8000 0 80000000
2 1 5 3 0 0 0 0 0 0 2 1 0 1 0 0 0 0 0 ff80 0 ffffff80
2 0 0 0 0 0 3 5 0 1 0 0 0 0 0 1 0 0 1 0 d 32
2 0 0 0 0 1 0 0 0 1 0 0 0 0 0 1 0 0 1 0 fffe fffffffe
2 0 0 2 0 0 0 1 0 0 2 1 0 0 0 1 0 0 3 5 4 34
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 3 2 65 0 0 4b
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 3 1 fffffff9 0 0 fffffff5
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 4 0 40000000 0 0 7fffffff
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 4 0 c0000000 0 0 80000000
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 7fffffff 1f 7fffffff 0 0 7ffffffe
3 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 3 0 64 0 0 64
3 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 3 1 fffffff6 0 0 fffffff1
5 0 0 0 0 0 0 0 0 0 2 0 100 1 0 0 0 0 1 0 0 101
5 0 0 1 0 0 0 0 0 0 2 1 0 0 0 0 2 0 1 7 0 10
5 0 0 0 0 0 0 1 0 0 1 0 50 0 0 1 0 0 60 0 3 f0
5 0 0 0 0 0 0 0 0 1 0 1 0 1 0 0 0 0 9 0 0 9

/* filelist.f */
+incdir+include
hw/ew_data_pkg.sv
hw/ew_cfg_pkg.sv
hw/ew_operand_cvt.sv
hw/ew_alu_mul_core.sv
hw/ew_y_core.sv
tb/ew_y_core_assertions.sv
tb/ew_y_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run; the exit status is nonzero unless the run passes
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ew_y_core_tb -o sim_ew_y_core &&
  ./obj_dir/sim_ew_y_core | tee /dev/stderr | grep -q "^Everything OK$" &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
